//--- dma_target_pkg.sv
/*
 * DMA target shared definitions
 * Widths, flit and header layouts, type and state encodings,
 * and the request bundle that drives the local RAM
 */
package dma_target_pkg;

  ////////////////////
  // Widths

  localparam int DATA_W = 32;
  localparam int TILE_W = 4;
  localparam int ID_W   = 4;
  localparam int SIZE_W = 8;

  // Largest local RAM the request bundle can reach, in words
  localparam int RAM_WORDS_MAX = 64;

  // Address bits needed for a RAM of the given word count
  function automatic int addr_w(input int words);
    return (words > 1) ? $clog2(words) : 1;
  endfunction

  localparam int RAM_AW    = addr_w(RAM_WORDS_MAX);
  // Header bits left over after all fields
  localparam int HDR_PAD_W = DATA_W - 2 * TILE_W - 2 - ID_W - SIZE_W - 1;

  ////////////////////
  // Encodings

  typedef enum logic [1:0] {
    PAYLOAD = 2'b00,
    HEADER  = 2'b01,
    LAST    = 2'b10,
    SINGLE  = 2'b11
  } flit_type_e;

  typedef enum logic [1:0] {
    L2R_REQ  = 2'b00,
    R2L_REQ  = 2'b01,
    L2R_RESP = 2'b10,
    R2L_RESP = 2'b11
  } pkt_type_e;

  typedef enum logic [3:0] {
    IDLE,
    WR_ADDR,
    WR_DATA,
    WR_RESP,
    RD_LADDR,
    RD_RADDR,
    RD_HDR,
    RD_ADDR,
    RD_DATA
  } ctrl_state_e;

  ////////////////////
  // Bundles

  typedef struct packed {
    flit_type_e        ftype;
    logic [DATA_W-1:0] content;
  } flit_t;

  // Header flit content, destination in the top bits
  typedef struct packed {
    logic [TILE_W-1:0]    dest;
    logic [TILE_W-1:0]    src;
    pkt_type_e            ptype;
    logic [ID_W-1:0]      id;
    logic [SIZE_W-1:0]    size;
    logic                 last;
    logic [HDR_PAD_W-1:0] pad;
  } hdr_t;

  typedef struct packed {
    logic [RAM_AW-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              en;
    logic              we;
  } ram_req_t;

endpackage

//--- dma_packet_buffer.sv
/*
 * DMA target input packet buffer
 * Circular flit FIFO between the NoC input port and the controller
 */
`timescale 1ns/1ps

module dma_packet_buffer #(
  parameter int DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  dma_target_pkg::flit_t in_flit_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output dma_target_pkg::flit_t out_flit_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i
);
  import dma_target_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  flit_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Ready drops only when every slot holds a flit
  assign in_ready_o  = (count != CNT_W'(DEPTH));
  assign out_valid_o = (count != '0);
  assign out_flit_o  = mem[rd_ptr];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // Flit storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit_i;
    end
  end

  // Pointers wrap at DEPTH, count tracks occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

endmodule

//--- dma_read_fifo.sv
/*
 * DMA target read data FIFO
 * Three-entry shift FIFO for RAM read words bound for the NoC,
 * with free-slot accounting that includes reads still in flight
 */
`timescale 1ns/1ps

module dma_read_fifo (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              push_i,
  input  logic [dma_target_pkg::DATA_W-1:0] push_data_i,
  input  logic                              rd_issue_i,
  input  logic                              pop_i,
  output logic [dma_target_pkg::DATA_W-1:0] head_o,
  output logic                              not_empty_o,
  output logic [1:0]                        free_o
);
  import dma_target_pkg::*;

  logic [DATA_W-1:0] data [3];
  // One-hot write position, bit 3 marks full
  logic [3:0]        pos;
  logic [1:0]        used;
  logic [1:0]        inflight;

  assign head_o      = data[0];
  assign not_empty_o = ~pos[0];

  // One-hot position to occupancy
  assign used   = {pos[3] | pos[2], pos[3] | pos[1]};
  // Slots not yet promised to an issued read
  assign free_o = 2'd3 - used - inflight;

  always_ff @(posedge clk) begin
    if (rst) begin
      pos      <= 4'b0001;
      inflight <= '0;
    end else begin
      if (push_i && !pop_i) begin
        pos <= pos << 1;
      end else if (!push_i && pop_i) begin
        pos <= pos >> 1;
      end
      // Issued reads return one cycle later as pushes
      inflight <= inflight + 2'(rd_issue_i) - 2'(push_i);
    end
  end

  ////////////////////
  // Data shifting

  for (genvar i = 0; i < 3; i++) begin : g_slot
    logic [DATA_W-1:0] above;

    // Top slot has nothing above it to shift down
    if (i < 2) begin : g_mid
      assign above = data[i+1];
    end else begin : g_top
      assign above = data[i];
    end

    always_ff @(posedge clk) begin
      if (pop_i) begin
        // Incoming word lands one below its write position
        if (push_i && pos[i+1]) begin
          data[i] <= push_data_i;
        end else begin
          data[i] <= above;
        end
      end else if (push_i && pos[i]) begin
        data[i] <= push_data_i;
      end
    end
  end

endmodule

//--- dma_local_ram.sv
/*
 * DMA target local RAM
 * Single-port word-addressed RAM, read data one cycle after request
 */
`timescale 1ns/1ps

module dma_local_ram #(
  parameter int WORDS = 64
) (
  input  logic                              clk,
  input  dma_target_pkg::ram_req_t          req_i,
  output logic [dma_target_pkg::DATA_W-1:0] rd_data_o,
  output logic                              rd_valid_o
);
  import dma_target_pkg::*;

  localparam int AW = addr_w(WORDS);

  logic [DATA_W-1:0] mem [WORDS];
  logic [AW-1:0]     idx;

  // Low address bits select the word
  assign idx = req_i.addr[AW-1:0];

  always_ff @(posedge clk) begin
    if (req_i.en) begin
      if (req_i.we) begin
        mem[idx] <= req_i.wdata;
      end else begin
        rd_data_o <= mem[idx];
      end
    end
    // Marks the cycle rd_data_o carries a fresh word
    rd_valid_o <= req_i.en & ~req_i.we;
  end

endmodule

//--- dma_target_ctrl.sv
/*
 * DMA target controller
 * Parses write and read requests, writes payload into the RAM,
 * issues RAM reads and splits read data into response packets
 */
`timescale 1ns/1ps

module dma_target_ctrl #(
  parameter logic [dma_target_pkg::TILE_W-1:0] TILE_ID      = '0,
  parameter int                                PACKET_FLITS = 8
) (
  input  logic                              clk,
  input  logic                              rst,
  input  dma_target_pkg::flit_t             buf_flit_i,
  input  logic                              buf_valid_i,
  output logic                              buf_ready_o,
  output dma_target_pkg::ram_req_t          ram_req_o,
  input  logic [dma_target_pkg::DATA_W-1:0] fifo_head_i,
  input  logic                              fifo_not_empty_i,
  input  logic [1:0]                        fifo_free_i,
  output logic                              fifo_pop_o,
  output dma_target_pkg::flit_t             out_flit_o,
  output logic                              out_valid_o,
  input  logic                              out_ready_i
);
  import dma_target_pkg::*;

  // Header and address flits leave this room for payload
  localparam logic [SIZE_W-1:0] PAYLOAD_MAX = SIZE_W'(PACKET_FLITS - 2);

  ctrl_state_e       state;
  ctrl_state_e       next_state;
  hdr_t              in_hdr;
  hdr_t              out_hdr;

  // Request parameters, word count counts down during writes
  logic [TILE_W-1:0] req_tile;
  logic [ID_W-1:0]   req_id;
  logic [SIZE_W-1:0] req_words;
  logic [RAM_AW-1:0] word_addr;
  logic [DATA_W-1:0] remote_addr;

  // Read progress: words in earlier packets, issued and sent in this one
  logic [SIZE_W-1:0] rd_sent;
  logic [SIZE_W-1:0] rd_issued;
  logic [SIZE_W-1:0] rd_popped;

  logic [SIZE_W-1:0] words_rest;
  logic [SIZE_W-1:0] pkt_words;
  logic              pkt_last;
  logic              data_last;
  logic              buf_take;
  logic              wr_word;
  logic              rd_issue;

  assign in_hdr   = hdr_t'(buf_flit_i.content);
  assign buf_take = buf_valid_i & buf_ready_o;
  assign wr_word  = (state == WR_DATA) & buf_valid_i;

  // Size of the current response packet
  assign words_rest = req_words - rd_sent;
  assign pkt_last   = (words_rest <= PAYLOAD_MAX);
  assign pkt_words  = pkt_last ? words_rest : PAYLOAD_MAX;
  assign data_last  = (rd_popped == pkt_words - 1'b1);

  // Read whenever a FIFO slot is free and the packet still needs words
  assign rd_issue = (state inside {RD_HDR, RD_ADDR, RD_DATA}) &&
                    (fifo_free_i != 2'd0) && (rd_issued != pkt_words);

  always_comb begin
    ram_req_o.addr  = word_addr;
    ram_req_o.wdata = buf_flit_i.content;
    ram_req_o.en    = wr_word | rd_issue;
    ram_req_o.we    = wr_word;
  end

  // Response header, back to the requester
  always_comb begin
    out_hdr      = '0;
    out_hdr.dest = req_tile;
    out_hdr.src  = TILE_ID;
    out_hdr.id   = req_id;
    if (state == WR_RESP) begin
      out_hdr.ptype = L2R_RESP;
      out_hdr.last  = 1'b1;
    end else begin
      out_hdr.ptype = R2L_RESP;
      out_hdr.size  = pkt_words;
      out_hdr.last  = pkt_last;
    end
  end

  ////////////////////
  // FSM

  always_comb begin
    next_state         = state;
    buf_ready_o        = 1'b0;
    out_valid_o        = 1'b0;
    out_flit_o.ftype   = PAYLOAD;
    out_flit_o.content = '0;
    fifo_pop_o         = 1'b0;
    case (state)
      IDLE: begin
        buf_ready_o = 1'b1;
        // Anything but a known request header is dropped
        if (buf_valid_i && (buf_flit_i.ftype inside {HEADER, SINGLE})) begin
          if (in_hdr.ptype == L2R_REQ) begin
            next_state = WR_ADDR;
          end else if (in_hdr.ptype == R2L_REQ) begin
            next_state = RD_LADDR;
          end
        end
      end
      WR_ADDR: begin
        buf_ready_o = 1'b1;
        if (buf_valid_i) begin
          next_state = (req_words == '0) ? WR_RESP : WR_DATA;
        end
      end
      WR_DATA: begin
        // One word written per consumed flit
        buf_ready_o = 1'b1;
        if (buf_valid_i && req_words == SIZE_W'(1)) begin
          next_state = WR_RESP;
        end
      end
      WR_RESP: begin
        out_valid_o        = 1'b1;
        out_flit_o.ftype   = SINGLE;
        out_flit_o.content = out_hdr;
        if (out_ready_i) begin
          next_state = IDLE;
        end
      end
      RD_LADDR: begin
        buf_ready_o = 1'b1;
        if (buf_valid_i) begin
          next_state = RD_RADDR;
        end
      end
      RD_RADDR: begin
        buf_ready_o = 1'b1;
        if (buf_valid_i) begin
          next_state = RD_HDR;
        end
      end
      RD_HDR: begin
        out_valid_o        = 1'b1;
        out_flit_o.ftype   = HEADER;
        out_flit_o.content = out_hdr;
        if (out_ready_i) begin
          next_state = RD_ADDR;
        end
      end
      RD_ADDR: begin
        // Remote byte address advances four per word already sent
        out_valid_o        = 1'b1;
        out_flit_o.content = remote_addr + (DATA_W'(rd_sent) << 2);
        if (out_ready_i) begin
          next_state = (pkt_words == '0) ? IDLE : RD_DATA;
        end
      end
      RD_DATA: begin
        out_valid_o        = fifo_not_empty_i;
        out_flit_o.ftype   = data_last ? LAST : PAYLOAD;
        out_flit_o.content = fifo_head_i;
        if (fifo_not_empty_i && out_ready_i) begin
          fifo_pop_o = 1'b1;
          if (data_last) begin
            next_state = pkt_last ? IDLE : RD_HDR;
          end
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      rd_sent   <= '0;
      rd_issued <= '0;
      rd_popped <= '0;
    end else begin
      state <= next_state;
      if (state == IDLE) begin
        rd_sent   <= '0;
        rd_issued <= '0;
        rd_popped <= '0;
      end
      if (rd_issue) begin
        rd_issued <= rd_issued + 1'b1;
      end
      if (fifo_pop_o) begin
        // Packet done, restart per-packet counts
        if (data_last) begin
          rd_sent   <= rd_sent + pkt_words;
          rd_issued <= '0;
          rd_popped <= '0;
        end else begin
          rd_popped <= rd_popped + 1'b1;
        end
      end
    end
  end

  // Request fields and the running RAM word address
  always_ff @(posedge clk) begin
    if (state == IDLE && buf_take) begin
      req_tile  <= in_hdr.src;
      req_id    <= in_hdr.id;
      req_words <= in_hdr.size;
    end
    if ((state == WR_ADDR || state == RD_LADDR) && buf_take) begin
      word_addr <= buf_flit_i.content[RAM_AW+1:2];
    end
    if (state == RD_RADDR && buf_take) begin
      remote_addr <= buf_flit_i.content;
    end
    if (wr_word) begin
      word_addr <= word_addr + 1'b1;
      req_words <= req_words - 1'b1;
    end
    if (rd_issue) begin
      word_addr <= word_addr + 1'b1;
    end
  end

endmodule

//--- dma_target_top.sv
/*
 * DMA target top level
 * Connects input buffer, controller, local RAM and read FIFO
 * between the NoC input and output ports
 */
`timescale 1ns/1ps

module dma_target_top #(
  parameter logic [dma_target_pkg::TILE_W-1:0] TILE_ID      = '0,
  parameter int                                PACKET_FLITS = 8,
  parameter int                                RAM_WORDS    = dma_target_pkg::RAM_WORDS_MAX
) (
  input  logic                  clk,
  input  logic                  rst,
  input  dma_target_pkg::flit_t noc_in_flit_i,
  input  logic                  noc_in_valid_i,
  output logic                  noc_in_ready_o,
  output dma_target_pkg::flit_t noc_out_flit_o,
  output logic                  noc_out_valid_o,
  input  logic                  noc_out_ready_i
);
  import dma_target_pkg::*;

  // Buffer to controller
  flit_t             buf_flit;
  logic              buf_valid;
  logic              buf_ready;
  // Controller, RAM and read FIFO
  ram_req_t          ram_req;
  logic [DATA_W-1:0] rd_data;
  logic              rd_valid;
  logic              rd_issue;
  logic [DATA_W-1:0] fifo_head;
  logic              fifo_not_empty;
  logic              fifo_pop;
  logic [1:0]        fifo_free;

  // Any RAM read counts as in flight toward the FIFO
  assign rd_issue = ram_req.en & ~ram_req.we;

  dma_packet_buffer #(
    .DEPTH (PACKET_FLITS)
  ) u_buffer (
    .clk         (clk),
    .rst         (rst),
    .in_flit_i   (noc_in_flit_i),
    .in_valid_i  (noc_in_valid_i),
    .in_ready_o  (noc_in_ready_o),
    .out_flit_o  (buf_flit),
    .out_valid_o (buf_valid),
    .out_ready_i (buf_ready)
  );

  dma_target_ctrl #(
    .TILE_ID      (TILE_ID),
    .PACKET_FLITS (PACKET_FLITS)
  ) u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .buf_flit_i       (buf_flit),
    .buf_valid_i      (buf_valid),
    .buf_ready_o      (buf_ready),
    .ram_req_o        (ram_req),
    .fifo_head_i      (fifo_head),
    .fifo_not_empty_i (fifo_not_empty),
    .fifo_free_i      (fifo_free),
    .fifo_pop_o       (fifo_pop),
    .out_flit_o       (noc_out_flit_o),
    .out_valid_o      (noc_out_valid_o),
    .out_ready_i      (noc_out_ready_i)
  );

  dma_local_ram #(
    .WORDS (RAM_WORDS)
  ) u_ram (
    .clk        (clk),
    .req_i      (ram_req),
    .rd_data_o  (rd_data),
    .rd_valid_o (rd_valid)
  );

  dma_read_fifo u_read_fifo (
    .clk         (clk),
    .rst         (rst),
    .push_i      (rd_valid),
    .push_data_i (rd_data),
    .rd_issue_i  (rd_issue),
    .pop_i       (fifo_pop),
    .head_o      (fifo_head),
    .not_empty_o (fifo_not_empty),
    .free_o      (fifo_free)
  );

endmodule

//--- tb_clock_gen.sv
/*
 * Testbench clock generator
 * Free-running clock, low at time zero
 */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter realtime PERIOD = 100.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2.0);
      clk_o = ~clk_o;
    end
  end

endmodule

//--- dma_target_chk.sv
/*
 * DMA target protocol assertions
 * Bound into the top level, watches the NoC output handshake
 * and the occupancy of the read data FIFO
 */
`timescale 1ns/1ps

module dma_target_chk (
  input logic                  clk,
  input logic                  rst,
  input dma_target_pkg::flit_t out_flit_i,
  input logic                  out_valid_i,
  input logic                  out_ready_i,
  input logic                  fifo_push_i,
  input logic                  fifo_pop_i
);
  import dma_target_pkg::*;

  // Failed assertions, read back by the testbench top
  int         fail_count;
  // Words held in the read FIFO
  logic [2:0] occ;

  always_ff @(posedge clk) begin
    if (rst) begin
      occ <= '0;
    end else begin
      occ <= occ + 3'(fifo_push_i) - 3'(fifo_pop_i);
    end
  end

  ////////////////////
  // NoC output

  // Output flit holds while the network refuses it
  out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_flit_i))
    else begin
      $error("NoC output flit dropped or changed under back-pressure");
      fail_count++;
    end

  ////////////////////
  // Read FIFO

  // A push into a full FIFO only works with a pop in the same cycle
  fifo_no_overflow: assert property (@(posedge clk) disable iff (rst)
    fifo_push_i |-> (occ < 3'd3) || fifo_pop_i)
    else begin
      $error("read FIFO pushed while full");
      fail_count++;
    end

  fifo_no_underflow: assert property (@(posedge clk) disable iff (rst)
    fifo_pop_i |-> (occ != 3'd0) || fifo_push_i)
    else begin
      $error("read FIFO popped while empty");
      fail_count++;
    end

endmodule

//--- tb_checker.sv
/*
 * Testbench output checker
 * Compares each flit accepted at the NoC output with the next
 * expected flit of the trace, counts mismatches and input stalls
 */
`timescale 1ns/1ps

module tb_checker (
  input  logic                  clk,
  input  logic                  rst,
  input  dma_target_pkg::flit_t flit_i,
  input  logic                  valid_i,
  input  logic                  ready_i,
  input  logic                  in_valid_i,
  input  logic                  in_ready_i,
  input  dma_target_pkg::flit_t exp_flit_i,
  input  int                    exp_total_i,
  output int                    exp_idx_o,
  output int                    checked_o,
  output int                    err_o,
  output int                    in_stalls_o
);
  import dma_target_pkg::*;

  // Sampled on the edge, inputs settle 1 ns after it
  always @(posedge clk) begin
    if (rst) begin
      exp_idx_o   <= 0;
      checked_o   <= 0;
      err_o       <= 0;
      in_stalls_o <= 0;
    end else begin
      // Full input buffer holds the offered flit back
      if (in_valid_i && !in_ready_i) begin
        in_stalls_o <= in_stalls_o + 1;
      end
      if (valid_i && ready_i) begin
        checked_o <= checked_o + 1;
        if (exp_idx_o >= exp_total_i) begin
          $display("Unexpected output flit at %0t, type %0d content %08h, trace has no more",
                   $time, flit_i.ftype, flit_i.content);
          err_o <= err_o + 1;
        end else begin
          // Type and content reported separately
          if (flit_i.ftype !== exp_flit_i.ftype) begin
            $display("FAIL %0t noc_out_flit_o.ftype expected %0d got %0d (flit %0d)",
                     $time, exp_flit_i.ftype, flit_i.ftype, exp_idx_o);
            err_o <= err_o + 1;
          end
          if (flit_i.content !== exp_flit_i.content) begin
            $display("FAIL %0t noc_out_flit_o.content expected %08h got %08h (flit %0d)",
                     $time, exp_flit_i.content, flit_i.content, exp_idx_o);
            err_o <= err_o + 1;
          end
          exp_idx_o <= exp_idx_o + 1;
        end
      end
    end
  end

endmodule

//--- tb_top.sv
/*
 * DMA target testbench top
 * Replays the request trace into the DUT, stalls the NoC output
 * at random and guards the run with a watchdog
 */
`timescale 1ns/1ps

module tb_top;
  import dma_target_pkg::*;

  localparam int                TRACE_MAX       = 128;
  localparam int                RESET_CYCLES    = 10;
  localparam int                CYCLES_PER_LINE = 40;
  localparam int                DRAIN_CYCLES    = 20;
  localparam int                HOLD_CYCLES     = 16;
  localparam logic [31:0]       SEED            = 32'hd602_4dd5;
  localparam logic [TILE_W-1:0] TILE_ID         = 4'h3;

  logic  clk;
  logic  rst;
  flit_t noc_in_flit;
  logic  noc_in_valid;
  logic  noc_in_ready;
  flit_t noc_out_flit;
  logic  noc_out_valid;
  logic  noc_out_ready;

  // Trace contents, input and expected flits kept apart
  flit_t in_mem  [TRACE_MAX];
  flit_t exp_mem [TRACE_MAX];
  int    in_count;
  int    exp_count;
  int    trace_lines;
  bit    loaded;

  flit_t exp_flit;
  int    exp_idx;
  int    checked;
  int    check_errors;
  int    other_errors;
  int    in_stalls;

  tb_clock_gen #(
    .PERIOD (100.0)
  ) u_clock (
    .clk_o (clk)
  );

  dma_target_top #(
    .TILE_ID      (TILE_ID),
    .PACKET_FLITS (8),
    .RAM_WORDS    (64)
  ) dut (
    .clk             (clk),
    .rst             (rst),
    .noc_in_flit_i   (noc_in_flit),
    .noc_in_valid_i  (noc_in_valid),
    .noc_in_ready_o  (noc_in_ready),
    .noc_out_flit_o  (noc_out_flit),
    .noc_out_valid_o (noc_out_valid),
    .noc_out_ready_i (noc_out_ready)
  );

  // Checker asks for the next expected flit by index
  assign exp_flit = (exp_idx < exp_count) ? exp_mem[exp_idx] : '0;

  tb_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .flit_i      (noc_out_flit),
    .valid_i     (noc_out_valid),
    .ready_i     (noc_out_ready),
    .in_valid_i  (noc_in_valid),
    .in_ready_i  (noc_in_ready),
    .exp_flit_i  (exp_flit),
    .exp_total_i (exp_count),
    .exp_idx_o   (exp_idx),
    .checked_o   (checked),
    .err_o       (check_errors),
    .in_stalls_o (in_stalls)
  );

  bind dma_target_top dma_target_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .out_flit_i  (noc_out_flit_o),
    .out_valid_i (noc_out_valid_o),
    .out_ready_i (noc_out_ready_i),
    .fifo_push_i (rd_valid),
    .fifo_pop_i  (fifo_pop)
  );

  ////////////////////
  // Tasks

  // Splits trace lines into input and expected flits
  task automatic load_trace();
    int                fd;
    int                n;
    int                ftype;
    int                line_no;
    byte               tag;
    string             line;
    logic [DATA_W-1:0] content;
    flit_t             f;
    line_no = 0;
    fd = $fopen("dma_trace.txt", "r");
    if (fd == 0) begin
      return;
    end
    while ($fgets(line, fd) > 0) begin
      line_no++;
      // Comments and blank lines carry no flit
      if (line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%c %d %h", tag, ftype, content);
        f.ftype   = flit_type_e'(ftype[1:0]);
        f.content = content;
        if (n != 3) begin
          $display("Trace line %0d could not be parsed", line_no);
          other_errors++;
        end else if (tag == "I" && in_count < TRACE_MAX) begin
          in_mem[in_count] = f;
          in_count++;
          trace_lines++;
        end else if (tag == "E" && exp_count < TRACE_MAX) begin
          exp_mem[exp_count] = f;
          exp_count++;
          trace_lines++;
        end else begin
          $display("Trace line %0d has an unknown tag or overflows the trace store",
                   line_no);
          other_errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  // Holds one flit on the input until an edge sees ready high
  task automatic send_flit(input flit_t f);
    noc_in_flit  = f;
    noc_in_valid = 1'b1;
    @(posedge clk);
    while (!noc_in_ready) begin
      @(posedge clk);
    end
    #1;
  endtask

  task automatic end_run();
    int assert_fails;
    int leftover;
    assert_fails = dut.u_chk.fail_count;
    leftover     = exp_count - exp_idx;
    if (leftover > 0) begin
      $display("%0d expected output flits never appeared", leftover);
      other_errors++;
    end
    if (in_count > 0 && in_stalls == 0) begin
      $display("NoC input never stalled although the output was held back");
      other_errors++;
    end
    $display("Checked %0d flits: %0d mismatches, %0d other errors, %0d assertion failures",
             checked, check_errors, other_errors, assert_fails);
    if (check_errors == 0 && other_errors == 0 && assert_fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  ////////////////////
  // Processes

  initial begin
    int i;
    rst          = 1'b1;
    noc_in_valid = 1'b0;
    noc_in_flit  = '0;
    load_trace();
    if (in_count == 0 || exp_count == 0) begin
      $display("Trace file dma_trace.txt is missing or holds no input and expected flits");
      other_errors++;
      end_run();
    end else begin
      loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
      // Requests go in back to back, the buffer stalls them when full
      for (i = 0; i < in_count; i++) begin
        send_flit(in_mem[i]);
      end
      noc_in_valid = 1'b0;
      noc_in_flit  = '0;
      wait (exp_idx >= exp_count);
      // Extra flits after the last expected one still get caught
      repeat (DRAIN_CYCLES) @(posedge clk);
      end_run();
    end
  end

  // Random output back-pressure
  initial begin
    noc_out_ready = 1'b0;
    void'($urandom(SEED));
    // First write response waits while the next request fills the input buffer
    wait (!rst);
    repeat (HOLD_CYCLES) @(posedge clk);
    forever begin
      @(posedge clk);
      #1;
      // About one cycle in four refuses the output flit
      noc_out_ready = (($urandom % 4) != 0);
    end
  end

  // Watchdog, budget scales with the trace length
  initial begin
    wait (loaded);
    repeat (CYCLES_PER_LINE * trace_lines) @(posedge clk);
    $display("Run timed out after %0d cycles with %0d of %0d expected flits seen",
             CYCLES_PER_LINE * trace_lines, exp_idx, exp_count);
    other_errors++;
    end_run();
  end

endmodule

//--- dma_trace.txt
# Tag: I = flit driven into the NoC input, E = flit expected at the NoC output
# Then flit type (0 payload, 1 header, 2 last, 3 single) and content in hex
# Write of 3 words at byte address 0x10, requester tile 5, id 1
I 1 35040C00
I 0 00000010
I 0 A0000001
I 0 A0000002
I 2 A0000003
E 3 53840200
# Write of 11 words at byte address 0x1C, id 2
I 1 35082C00
I 0 0000001C
I 0 B0000004
I 0 B0000005
I 0 B0000006
I 0 B0000007
I 0 B0000008
I 0 B0000009
I 0 B000000A
I 0 B000000B
I 0 B000000C
I 0 B000000D
I 2 B000000E
E 3 53880200
# Read of 3 words from 0x10 to remote 0x80001000, id 3
I 1 354C0C00
I 0 00000010
I 2 80001000
E 1 53CC0E00
E 0 80001000
E 0 A0000001
E 0 A0000002
E 2 A0000003
# Read of 14 words from 0x10 to remote 0x80002000, id 4, split 6 + 6 + 2
I 1 35503800
I 0 00000010
I 2 80002000
E 1 53D01800
E 0 80002000
E 0 A0000001
E 0 A0000002
E 0 A0000003
E 0 B0000004
E 0 B0000005
E 2 B0000006
E 1 53D01800
E 0 80002018
E 0 B0000007
E 0 B0000008
E 0 B0000009
E 0 B000000A
E 0 B000000B
E 2 B000000C
E 1 53D00A00
E 0 80002030
E 0 B000000D
E 2 B000000E

//--- tb.f
dma_target_pkg.sv
dma_packet_buffer.sv
dma_read_fifo.sv
dma_local_ram.sv
dma_target_ctrl.sv
dma_target_top.sv
tb_clock_gen.sv
dma_target_chk.sv
tb_checker.sv
tb_top.sv
